/* Makefile */
# Verilator build for the conversion unit testbench

VERILATOR ?= verilator
TOP ?= fp_convert_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* source/fp_conv_pkg.sv */
package fp_conv_pkg;

	// Word and field widths of the single-precision format
	localparam int WORD_WIDTH = 32;
	localparam int EXP_WIDTH = 8;
	localparam int MANT_WIDTH = 23;

	localparam int EXP_BIAS = 127;

	// Returned for NaN, infinity and out-of-range float to int
	localparam logic [WORD_WIDTH-1:0] INVALID_INT = 32'h8000_0000;

	typedef enum logic [0:0] {
		OP_ITOF = 1'b0,
		OP_FTOI = 1'b1
	} conv_op_t;

	// IEEE-754 single-precision layout
	typedef struct packed {
		logic sign;
		logic [EXP_WIDTH-1:0] exponent;
		logic [MANT_WIDTH-1:0] mantissa;
	} float_t;

	// One request at the top level input
	typedef struct packed {
		conv_op_t op;
		logic [WORD_WIDTH-1:0] operand;
	} conv_req_t;

endpackage

/* source/fp_convert.sv */
`timescale 1ns/1ps

module fp_convert
	import fp_conv_pkg::*;
(
	input logic clk,
	input logic rst,
	input conv_req_t req,
	input logic req_valid,
	output logic [WORD_WIDTH-1:0] result,
	output logic result_valid
);

	logic itof_in_valid;
	logic ftoi_in_valid;
	logic [WORD_WIDTH-1:0] itof_z;
	logic [WORD_WIDTH-1:0] ftoi_z;
	logic itof_z_valid;
	logic ftoi_z_valid;

	// Steer by operation code
	assign itof_in_valid = req_valid && (req.op == OP_ITOF);
	assign ftoi_in_valid = req_valid && (req.op == OP_FTOI);

	fp_itof itof_i (
		.clk(clk),
		.rst(rst),
		.input_a(req.operand),
		.input_valid(itof_in_valid),
		.output_z(itof_z),
		.output_valid_z(itof_z_valid)
	);

	fp_ftoi ftoi_i (
		.clk(clk),
		.rst(rst),
		.input_a(req.operand),
		.input_valid(ftoi_in_valid),
		.output_z(ftoi_z),
		.output_valid_z(ftoi_z_valid)
	);

	// Same latency on both paths, so never two results in one cycle
	assign result_valid = itof_z_valid || ftoi_z_valid;

	always_comb begin
		if (itof_z_valid)
			result = itof_z;
		else if (ftoi_z_valid)
			result = ftoi_z;
		else
			result = '0;
	end

endmodule

/* source/fp_ftoi.sv */
`timescale 1ns/1ps

module fp_ftoi
	import fp_conv_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [WORD_WIDTH-1:0] input_a,
	input logic input_valid,
	output logic [WORD_WIDTH-1:0] output_z,
	output logic output_valid_z
);

	localparam int SH_WIDTH = $clog2(WORD_WIDTH);
	// Zeros below the mantissa so the hidden bit lands on the top bit
	localparam int MAG_PAD = WORD_WIDTH - MANT_WIDTH - 1;

	// Input classes
	localparam logic [1:0] CL_NORM = 2'd0;
	localparam logic [1:0] CL_SMALL = 2'd1;
	localparam logic [1:0] CL_SPECIAL = 2'd2;

	// Stage 1, unpack and classify
	float_t in_f;
	float_t s1_f;
	logic [1:0] s1_class_tmp, s1_class;
	logic s1_valid;

	assign in_f = input_a;

	always_comb begin
		if (in_f.exponent == '1)
			s1_class_tmp = CL_SPECIAL;
		else if (in_f.exponent < EXP_WIDTH'(EXP_BIAS))
			// Zero and denormals end up here too
			s1_class_tmp = CL_SMALL;
		else
			s1_class_tmp = CL_NORM;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= input_valid;
	end

	always_ff @(posedge clk) begin
		if (input_valid) begin
			s1_f <= in_f;
			s1_class <= s1_class_tmp;
		end
	end

	// Stage 2, unbiased exponent and hidden bit
	logic [EXP_WIDTH-1:0] s2_exp;
	logic [MANT_WIDTH:0] s2_mant;
	logic [1:0] s2_class;
	logic s2_sign;
	logic s2_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2_exp <= s1_f.exponent - EXP_WIDTH'(EXP_BIAS);
			s2_mant <= {1'b1, s1_f.mantissa};
			s2_class <= s1_class;
			s2_sign <= s1_f.sign;
		end
	end

	// Stage 3, distance from the exponent to the top bit
	logic [SH_WIDTH-1:0] s3_shift_tmp, s3_shift;
	logic [EXP_WIDTH-1:0] s3_exp;
	logic [MANT_WIDTH:0] s3_mant;
	logic [1:0] s3_class;
	logic s3_sign;
	logic s3_valid;

	always_comb begin
		if (s2_exp < EXP_WIDTH'(WORD_WIDTH))
			s3_shift_tmp = SH_WIDTH'(WORD_WIDTH - 1) - SH_WIDTH'(s2_exp);
		else
			s3_shift_tmp = '0;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s3_valid <= 1'b0;
		else
			s3_valid <= s2_valid;
	end

	always_ff @(posedge clk) begin
		if (s2_valid) begin
			s3_shift <= s3_shift_tmp;
			s3_exp <= s2_exp;
			s3_mant <= s2_mant;
			s3_class <= s2_class;
			s3_sign <= s2_sign;
		end
	end

	// Stage 4, right shift drops the fraction
	logic [WORD_WIDTH-1:0] s4_mag;
	logic [EXP_WIDTH-1:0] s4_exp;
	logic [1:0] s4_class;
	logic s4_sign;
	logic s4_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s4_valid <= 1'b0;
		else
			s4_valid <= s3_valid;
	end

	always_ff @(posedge clk) begin
		if (s3_valid) begin
			s4_mag <= {s3_mant, {MAG_PAD{1'b0}}} >> s3_shift;
			s4_exp <= s3_exp;
			s4_class <= s3_class;
			s4_sign <= s3_sign;
		end
	end

	// Stage 5, range check and sign
	logic s5_over;
	logic [WORD_WIDTH-1:0] s5_value_tmp, s5_value;
	logic s5_valid;

	always_comb begin
		// Exactly -2^31 is the one representable value at exponent 31
		s5_over = (s4_exp > EXP_WIDTH'(WORD_WIDTH - 1)) ||
			(s4_exp == EXP_WIDTH'(WORD_WIDTH - 1) && !(s4_sign && s4_mag == INVALID_INT));
		if (s4_class == CL_SPECIAL)
			s5_value_tmp = INVALID_INT;
		else if (s4_class == CL_SMALL)
			s5_value_tmp = '0;
		else if (s5_over)
			s5_value_tmp = INVALID_INT;
		else
			s5_value_tmp = s4_sign ? -s4_mag : s4_mag;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s5_valid <= 1'b0;
		else
			s5_valid <= s4_valid;
	end

	always_ff @(posedge clk) begin
		if (s4_valid)
			s5_value <= s5_value_tmp;
	end

	// Stage 6, output register
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			output_valid_z <= 1'b0;
		else
			output_valid_z <= s5_valid;
	end

	always_ff @(posedge clk) begin
		if (s5_valid)
			output_z <= s5_value;
	end

endmodule

/* source/fp_itof.sv */
`timescale 1ns/1ps

module fp_itof
	import fp_conv_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [WORD_WIDTH-1:0] input_a,
	input logic input_valid,
	output logic [WORD_WIDTH-1:0] output_z,
	output logic output_valid_z
);

	localparam int LZ_WIDTH = $clog2(WORD_WIDTH);
	// Position of the guard bit after normalisation
	localparam int GRD = WORD_WIDTH - MANT_WIDTH - 2;

	// Stage-state codes
	localparam logic [1:0] ST_CLZ = 2'd0;
	localparam logic [1:0] ST_SHIFT = 2'd1;
	localparam logic [1:0] ST_ROUND = 2'd2;
	localparam logic [1:0] ST_PACK = 2'd3;

	// Stage 1, sign and magnitude
	logic [WORD_WIDTH-1:0] s1_value_tmp, s1_value;
	logic [1:0] s1_state_tmp, s1_state;
	logic s1_sign;
	logic s1_valid;

	always_comb begin
		if (input_a == '0) begin
			// Zero bypasses normalisation
			s1_value_tmp = '0;
			s1_state_tmp = ST_PACK;
		end else begin
			s1_value_tmp = input_a[WORD_WIDTH-1] ? -input_a : input_a;
			s1_state_tmp = ST_CLZ;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= input_valid;
	end

	always_ff @(posedge clk) begin
		if (input_valid) begin
			s1_value <= s1_value_tmp;
			s1_state <= s1_state_tmp;
			s1_sign <= input_a[WORD_WIDTH-1];
		end
	end

	// Stage 2, leading zero count
	logic [LZ_WIDTH-1:0] lz, s2_lz;
	logic [WORD_WIDTH-1:0] s2_value;
	logic [1:0] s2_state;
	logic s2_sign;
	logic s2_valid;

	lead_zero_count #(
		.WIDTH(WORD_WIDTH)
	) lzc_i (
		.value(s1_value),
		.count(lz)
	);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2_value <= s1_value;
			s2_state <= s1_state;
			s2_sign <= s1_sign;
			s2_lz <= lz;
		end
	end

	// Stage 3, normalise so the leading one sits at the top
	logic [WORD_WIDTH-1:0] s3_value;
	logic [LZ_WIDTH-1:0] s3_lz;
	logic [1:0] s3_state;
	logic s3_sign;
	logic s3_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s3_valid <= 1'b0;
		else
			s3_valid <= s2_valid;
	end

	always_ff @(posedge clk) begin
		if (s2_valid) begin
			if (s2_state == ST_CLZ) begin
				s3_value <= s2_value << s2_lz;
				s3_state <= ST_SHIFT;
			end else begin
				s3_value <= s2_value;
				s3_state <= ST_PACK;
			end
			s3_lz <= s2_lz;
			s3_sign <= s2_sign;
		end
	end

	// Stage 4, split off guard, round and sticky, biased exponent
	logic [EXP_WIDTH-1:0] s4_exp_tmp, s4_exp;
	logic [MANT_WIDTH:0] s4_mant_tmp, s4_mant;
	logic s4_guard_tmp, s4_guard;
	logic s4_round_tmp, s4_round;
	logic s4_sticky_tmp, s4_sticky;
	logic [1:0] s4_state_tmp, s4_state;
	logic s4_sign;
	logic s4_valid;

	always_comb begin
		if (s3_state == ST_SHIFT) begin
			s4_exp_tmp = EXP_WIDTH'(EXP_BIAS + WORD_WIDTH - 1) - EXP_WIDTH'(s3_lz);
			s4_mant_tmp = s3_value[WORD_WIDTH-1 -: MANT_WIDTH+1];
			s4_guard_tmp = s3_value[GRD];
			s4_round_tmp = s3_value[GRD-1];
			s4_sticky_tmp = |s3_value[GRD-2:0];
			s4_state_tmp = ST_ROUND;
		end else begin
			s4_exp_tmp = '0;
			s4_mant_tmp = '0;
			s4_guard_tmp = 1'b0;
			s4_round_tmp = 1'b0;
			s4_sticky_tmp = 1'b0;
			s4_state_tmp = ST_PACK;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s4_valid <= 1'b0;
		else
			s4_valid <= s3_valid;
	end

	always_ff @(posedge clk) begin
		if (s3_valid) begin
			s4_exp <= s4_exp_tmp;
			s4_mant <= s4_mant_tmp;
			s4_guard <= s4_guard_tmp;
			s4_round <= s4_round_tmp;
			s4_sticky <= s4_sticky_tmp;
			s4_state <= s4_state_tmp;
			s4_sign <= s3_sign;
		end
	end

	// Stage 5, round to nearest even
	logic [MANT_WIDTH+1:0] s5_sum;
	logic [EXP_WIDTH-1:0] s5_exp_tmp, s5_exp;
	logic [MANT_WIDTH:0] s5_mant_tmp, s5_mant;
	logic s5_sign;
	logic s5_valid;

	always_comb begin
		s5_sum = {1'b0, s4_mant} + 1'b1;
		s5_mant_tmp = s4_mant;
		s5_exp_tmp = s4_exp;
		if (s4_state == ST_ROUND && s4_guard && (s4_round || s4_sticky || s4_mant[0])) begin
			if (s5_sum[MANT_WIDTH+1]) begin
				// Mantissa carried out, renormalise
				s5_mant_tmp = s5_sum[MANT_WIDTH+1:1];
				s5_exp_tmp = s4_exp + 1'b1;
			end else begin
				s5_mant_tmp = s5_sum[MANT_WIDTH:0];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s5_valid <= 1'b0;
		else
			s5_valid <= s4_valid;
	end

	always_ff @(posedge clk) begin
		if (s4_valid) begin
			s5_exp <= s5_exp_tmp;
			s5_mant <= s5_mant_tmp;
			s5_sign <= s4_sign;
		end
	end

	// Stage 6, pack, hidden bit dropped
	float_t z_tmp;

	always_comb begin
		z_tmp.sign = s5_sign;
		z_tmp.exponent = s5_exp;
		z_tmp.mantissa = s5_mant[MANT_WIDTH-1:0];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			output_valid_z <= 1'b0;
		else
			output_valid_z <= s5_valid;
	end

	always_ff @(posedge clk) begin
		if (s5_valid)
			output_z <= z_tmp;
	end

endmodule

/* source/lead_zero_count.sv */
`timescale 1ns/1ps

module lead_zero_count #(
	parameter int WIDTH = 32,
	localparam int COUNT_WIDTH = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
	input logic [WIDTH-1:0] value,
	output logic [COUNT_WIDTH-1:0] count
);

	// Scan upward so the highest set bit wins
	always_comb begin
		count = '0;
		for (int i = 0; i < WIDTH; i++) begin
			if (value[i]) begin
				count = COUNT_WIDTH'(WIDTH - 1 - i);
			end
		end
	end

endmodule

/* sources.f */
+incdir+test
source/fp_conv_pkg.sv
source/lead_zero_count.sv
source/fp_itof.sv
source/fp_ftoi.sv
source/fp_convert.sv
test/fp_convert_tb.sv

/* test/fp_convert_model.svh */
`ifndef FP_CONVERT_MODEL_SVH
`define FP_CONVERT_MODEL_SVH

localparam logic [31:0] MODEL_INVALID_INT = 32'h8000_0000;

// Signed integer to single precision, round to nearest, ties to even
function automatic logic [31:0] itof_model(input logic [31:0] a);
	logic sign;
	logic [31:0] mag;
	logic [31:0] mant;
	logic [31:0] rem;
	logic [31:0] half;
	logic [7:0] exp;
	int msb;
	int shift;
	if (a == 32'h0)
		return 32'h0;
	sign = a[31];
	mag = sign ? (~a + 32'd1) : a;
	msb = 0;
	for (int i = 0; i < 32; i++) begin
		if (mag[i])
			msb = i;
	end
	exp = 8'(127 + msb);
	if (msb <= 23) begin
		mant = mag << (23 - msb);
	end else begin
		// Compare the dropped bits against one half ulp
		shift = msb - 23;
		mant = mag >> shift;
		rem = mag & ((32'd1 << shift) - 32'd1);
		half = 32'd1 << (shift - 1);
		if (rem > half || (rem == half && mant[0]))
			mant = mant + 32'd1;
		if (mant[24]) begin
			mant = mant >> 1;
			exp = exp + 8'd1;
		end
	end
	return {sign, exp, mant[22:0]};
endfunction

// Single precision to signed integer, truncated toward zero
function automatic logic [31:0] ftoi_model(input logic [31:0] f);
	logic sign;
	logic [7:0] biased;
	logic [63:0] mag;
	int unbiased;
	sign = f[31];
	biased = f[30:23];
	if (biased == 8'hff)
		return MODEL_INVALID_INT;
	if (biased < 8'd127)
		return 32'h0;
	unbiased = int'(biased) - 127;
	if (unbiased > 31)
		return MODEL_INVALID_INT;
	// Significand with hidden bit, scaled by 2^(unbiased-23)
	mag = {40'h0, 1'b1, f[22:0]};
	if (unbiased >= 23)
		mag = mag << (unbiased - 23);
	else
		mag = mag >> (23 - unbiased);
	if (sign) begin
		if (mag > 64'h8000_0000)
			return MODEL_INVALID_INT;
		return ~mag[31:0] + 32'd1;
	end
	if (mag > 64'h7fff_ffff)
		return MODEL_INVALID_INT;
	return mag[31:0];
endfunction

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

`endif

/* test/fp_convert_tb.sv */
`timescale 1ns/1ps

module fp_convert_tb
	import fp_conv_pkg::*;
();

	`include "fp_convert_model.svh"

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int LATENCY = 6;
	localparam int NUM_RANDOM = 200;
	localparam int NUM_MIXED = 100;
	localparam int NUM_TESTS = 6;
	localparam int TOTAL_REQUESTS = 7 + 10 + 2 * NUM_RANDOM + NUM_MIXED;
	localparam int TIMEOUT_NS =
		(TOTAL_REQUESTS + LATENCY * NUM_TESTS + RESET_CYCLES) * CLK_PERIOD * 2;

	logic clk;
	logic rst;
	conv_req_t req;
	logic req_valid;
	logic [31:0] result;
	logic result_valid;

	logic [31:0] lfsr_state = 32'h4795;
	int cycle = 0;
	logic [31:0] expected_q[$];
	conv_op_t op_q[$];
	int due_q[$];

	fp_convert dut_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_valid(req_valid),
		.result(result),
		.result_valid(result_valid)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic [31:0] random_bits(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// One request on the next edge with its expected value queued
	task automatic issue(input conv_op_t op, input logic [31:0] operand);
		conv_req_t r;
		r.op = op;
		r.operand = operand;
		@(posedge clk);
		req <= r;
		req_valid <= 1'b1;
		if (op == OP_ITOF)
			expected_q.push_back(itof_model(operand));
		else
			expected_q.push_back(ftoi_model(operand));
		op_q.push_back(op);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	task automatic drain();
		idle_cycle();
		while (expected_q.size() != 0)
			@(posedge clk);
	endtask

	// Results and latency checked at the falling edge
	always @(negedge clk) begin
		logic [31:0] expected;
		conv_op_t op;
		int due;
		if (rst) begin
			assert (result_valid == 1'b0)
				else stop_with_error($sformatf("Mismatch result_valid: got %h, expected %h",
					result_valid, 1'b0));
		end else begin
			if (result_valid) begin
				assert (expected_q.size() != 0)
					else stop_with_error("result_valid went high with no request outstanding");
				expected = expected_q.pop_front();
				op = op_q.pop_front();
				due = due_q.pop_front();
				assert (cycle == due)
					else stop_with_error($sformatf("%s result arrived at cycle %0d, due at %0d",
						op.name(), cycle, due));
				assert (result == expected)
					else stop_with_error($sformatf("Mismatch result (%s): got %h, expected %h",
						op.name(), result, expected));
			end else if (due_q.size() != 0) begin
				assert (cycle < due_q[0])
					else stop_with_error("No result_valid six cycles after a request");
			end
			if (req_valid)
				due_q.push_back(cycle + LATENCY);
		end
	end

	task automatic reset_and_idle();
		rst <= 1'b1;
		req <= '0;
		req_valid <= 1'b0;
		repeat (RESET_CYCLES)
			@(negedge clk);
		@(posedge clk);
		rst <= 1'b0;
		repeat (8) begin
			@(negedge clk);
			assert (result_valid == 1'b0)
				else stop_with_error($sformatf("Mismatch result_valid: got %h, expected %h",
					result_valid, 1'b0));
		end
	endtask

	task automatic itof_corner_cases();
		issue(OP_ITOF, 32'h0000_0000);
		issue(OP_ITOF, 32'h0000_0001);
		issue(OP_ITOF, 32'hffff_ffff);
		// Ties on the 24 bit boundary
		issue(OP_ITOF, 32'd16777217);
		issue(OP_ITOF, 32'd16777219);
		issue(OP_ITOF, 32'h7fff_ffff);
		issue(OP_ITOF, 32'h8000_0000);
		drain();
	endtask

	task automatic itof_random_operands();
		for (int i = 0; i < NUM_RANDOM; i++)
			issue(OP_ITOF, random_bits(32));
		drain();
	endtask

	task automatic ftoi_corner_cases();
		issue(OP_FTOI, 32'h0000_0000);
		issue(OP_FTOI, 32'h8000_0000);
		issue(OP_FTOI, 32'h0040_0001);
		issue(OP_FTOI, 32'h3f00_0000);
		issue(OP_FTOI, 32'hc030_0000);
		issue(OP_FTOI, 32'h4e6e_6b28);
		// 2^31 overflows and -2^31 fits exactly
		issue(OP_FTOI, 32'h4f00_0000);
		issue(OP_FTOI, 32'hcf00_0000);
		issue(OP_FTOI, 32'h7f80_0000);
		issue(OP_FTOI, 32'h7fc0_0000);
		drain();
	endtask

	task automatic ftoi_random_patterns();
		for (int i = 0; i < NUM_RANDOM; i++)
			issue(OP_FTOI, random_bits(32));
		drain();
	endtask

	task automatic mixed_stream();
		logic [31:0] gap;
		conv_op_t op;
		for (int i = 0; i < NUM_MIXED; i++) begin
			if (i % 2 == 0)
				op = OP_ITOF;
			else
				op = OP_FTOI;
			issue(op, random_bits(32));
			gap = random_bits(1);
			if (gap[0])
				idle_cycle();
		end
		drain();
	endtask

	initial begin
		#(TIMEOUT_NS);
		stop_with_error($sformatf("Run timed out after %0d ns", TIMEOUT_NS));
	end

	initial begin
		reset_and_idle();
		itof_corner_cases();
		itof_random_operands();
		ftoi_corner_cases();
		ftoi_random_patterns();
		mixed_stream();
		$display("All tests passed");
		$finish;
	end

endmodule
